// File: Bender.yml
package:
  name: led_panel

sources:
  - include_dirs:
      - design
    files:
      - design/led_types_pkg.sv
      - design/led_bus_pkg.sv
      - design/led_tick_timer.sv
      - design/led_mode_fsm.sv
      - design/led_event_flash.sv
      - design/led_rate_bar.sv
      - design/led_pattern_mux.sv
      - design/led_panel_top.sv
  - target: test
    files:
      - tb/tb_led_panel_assert.sv
      - tb/tb_led_panel.sv

// File: design/led_bus_pkg.sv
package led_bus_pkg;

  // ---------------------------------------------------------------------
  // wishbone classic, 32-bit data, word addresses
  // ---------------------------------------------------------------------

  // master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // register map
  localparam logic [1:0] ADR_CTRL   = 2'd0;  // read/write
  localparam logic [1:0] ADR_RATE   = 2'd1;  // read only
  localparam logic [1:0] ADR_STATUS = 2'd2;  // read only, {seen, mode}

endpackage

// File: design/led_event_flash.sv
`include "led_settings.svh"

module led_event_flash (
  input  logic                       clock,
  input  logic                       rst_i,
  input  led_types_pkg::led_events_t events_i,
  output led_types_pkg::led_events_t flash_o
);

  localparam int unsigned NEV = $bits(led_types_pkg::led_events_t);
  localparam int unsigned FW  = $clog2(`LED_FLASH_LEN + 1);

  logic [NEV-1:0] ev_q;
  logic [FW-1:0]  cnt_q[NEV];
  logic [NEV-1:0] lit;

  // ---------------------------------------------------------------------
  // pulse stretchers
  // ---------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (rst_i) begin
      ev_q <= '0;
      for (int i = 0; i < NEV; i++) cnt_q[i] <= '0;
    end else begin
      ev_q <= events_i;
      for (int i = 0; i < NEV; i++) begin
        // a new pulse restarts the flash
        if (ev_q[i])          cnt_q[i] <= FW'(`LED_FLASH_LEN);
        else if (cnt_q[i] != '0) cnt_q[i] <= cnt_q[i] - 1'b1;
      end
    end
  end

  // lit while counting down
  always_comb begin
    for (int i = 0; i < NEV; i++) lit[i] = (cnt_q[i] != '0);
  end

  assign flash_o = led_types_pkg::led_events_t'(lit);

endmodule

// File: design/led_mode_fsm.sv
module led_mode_fsm (
  input  logic                     clock,
  input  logic                     rst_i,
  input  logic                     mmcm_locked_i,
  input  logic                     resync_i,
  input  logic                     cluster_any_i,
  input  led_types_pkg::led_ctrl_u ctrl_i,
  output led_types_pkg::led_mode_e mode_o,
  output logic                     cluster_seen_o
);

  logic                     locked_q;
  logic                     resync_q;
  logic                     seen_q;
  logic                     seen_next;
  led_types_pkg::led_mode_e mode_q;
  led_types_pkg::led_mode_e mode_next;

  // ---------------------------------------------------------------------
  // input register
  // ---------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (rst_i) begin
      locked_q <= 1'b0;
      resync_q <= 1'b0;
    end else begin
      locked_q <= mmcm_locked_i;
      resync_q <= resync_i;
    end
  end

  // cluster-seen flag, resync wins over a new cluster
  always_comb begin
    if (resync_q)           seen_next = 1'b0;
    else if (cluster_any_i) seen_next = 1'b1;
    else                    seen_next = seen_q;
  end

  // ---------------------------------------------------------------------
  // mode priority
  // ---------------------------------------------------------------------
  always_comb begin
    if (!locked_q)
      mode_next = led_types_pkg::MODE_ERROR;
    else if (ctrl_i.sync.sync_en)
      mode_next = led_types_pkg::MODE_SYNC;
    // scanner until the first cluster, unless the host skips it
    else if (!seen_next && !ctrl_i.cfg.cylon_skip)
      mode_next = led_types_pkg::MODE_CYLON;
    else
      mode_next = led_types_pkg::MODE_LOGIC;
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      seen_q <= 1'b0;
      mode_q <= led_types_pkg::MODE_ERROR;
    end else begin
      seen_q <= seen_next;
      mode_q <= mode_next;
    end
  end

  assign mode_o         = mode_q;
  assign cluster_seen_o = seen_q;

endmodule

// File: design/led_panel_top.sv
`include "led_settings.svh"

module led_panel_top (
  input  logic                       clock,
  input  logic                       rst_i,
  input  logic                       mmcm_locked_i,
  input  led_types_pkg::led_link_t   link_i,
  input  led_types_pkg::led_events_t events_i,
  input  logic [7:0]                 cluster_count_i,
  input  led_bus_pkg::wb_req_t       wb_req_i,
  output led_bus_pkg::wb_rsp_t       wb_rsp_o,
  output logic [15:0]                led_o
);

  led_types_pkg::led_ticks_t  ticks;
  led_types_pkg::led_mode_e   mode;
  led_types_pkg::led_events_t flash;
  led_types_pkg::led_ctrl_u   ctrl_q;
  logic                       cluster_seen;
  logic                       cluster_any;
  logic [`LED_RATE_W-1:0]     rate;
  logic [7:0]                 bar;
  logic                       req;
  logic                       ack_q;
  logic [31:0]                rdat_q;
  logic [31:0]                rdat;

  // ---------------------------------------------------------------------
  // wishbone slave
  // ---------------------------------------------------------------------
  assign req = wb_req_i.cyc && wb_req_i.stb;

  // read mux, unmapped reads give zero
  always_comb begin
    case (wb_req_i.adr)
      led_bus_pkg::ADR_CTRL:   rdat = ctrl_q;
      led_bus_pkg::ADR_RATE:   rdat = 32'(rate);
      led_bus_pkg::ADR_STATUS: rdat = {29'd0, cluster_seen, mode};
      default:                 rdat = '0;
    endcase
  end

  // ack one cycle after the request, never two in a row
  always_ff @(posedge clock) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      ctrl_q <= '0;
    end else begin
      ack_q <= req && !ack_q;
      // only ctrl is writable
      if (req && !ack_q && wb_req_i.we && wb_req_i.adr == led_bus_pkg::ADR_CTRL)
        ctrl_q <= wb_req_i.dat;
    end
  end

  // read data held with ack
  always_ff @(posedge clock) begin
    if (req && !ack_q) rdat_q <= rdat;
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = ack_q ? rdat_q : 32'd0;

  // ---------------------------------------------------------------------
  // display pipeline
  // ---------------------------------------------------------------------
  led_tick_timer u_timer (
    .clock   (clock),
    .rst_i   (rst_i),
    .ticks_o (ticks)
  );

  led_mode_fsm u_fsm (
    .clock          (clock),
    .rst_i          (rst_i),
    .mmcm_locked_i  (mmcm_locked_i),
    .resync_i       (events_i.resync),
    .cluster_any_i  (cluster_any),
    .ctrl_i         (ctrl_q),
    .mode_o         (mode),
    .cluster_seen_o (cluster_seen)
  );

  led_event_flash u_flash (
    .clock    (clock),
    .rst_i    (rst_i),
    .events_i (events_i),
    .flash_o  (flash)
  );

  led_rate_bar u_rate (
    .clock           (clock),
    .rst_i           (rst_i),
    .window_i        (ticks.window),
    .cluster_count_i (cluster_count_i),
    .cluster_any_o   (cluster_any),
    .rate_o          (rate),
    .bar_o           (bar)
  );

  led_pattern_mux u_mux (
    .clock          (clock),
    .rst_i          (rst_i),
    .ticks_i        (ticks),
    .mode_i         (mode),
    .ctrl_i         (ctrl_q),
    .link_i         (link_i),
    .flash_i        (flash),
    .bar_i          (bar),
    .cluster_seen_i (cluster_seen),
    .led_o          (led_o)
  );

endmodule

// File: design/led_pattern_mux.sv
module led_pattern_mux (
  input  logic                       clock,
  input  logic                       rst_i,
  input  led_types_pkg::led_ticks_t  ticks_i,
  input  led_types_pkg::led_mode_e   mode_i,
  input  led_types_pkg::led_ctrl_u   ctrl_i,
  input  led_types_pkg::led_link_t   link_i,
  input  led_types_pkg::led_events_t flash_i,
  input  logic [7:0]                 bar_i,
  input  logic                       cluster_seen_i,
  output logic [15:0]                led_o
);

  logic        blink_q;
  logic [2:0]  pos_q;
  logic        down_q;
  logic [15:0] led_err;
  logic [15:0] led_logic;
  logic [15:0] led_cylon;
  logic [15:0] led_sel;
  logic [15:0] led_q;

  // ---------------------------------------------------------------------
  // blink phase and cylon scanner
  // ---------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (rst_i) begin
      blink_q <= 1'b0;
      pos_q   <= '0;
      down_q  <= 1'b0;
    end else begin
      if (ticks_i.blink) blink_q <= ~blink_q;
      if (ticks_i.scan) begin
        // turn around at either end
        if (!down_q && pos_q == 3'd7) begin
          down_q <= 1'b1;
          pos_q  <= 3'd6;
        end else if (down_q && pos_q == 3'd0) begin
          down_q <= 1'b0;
          pos_q  <= 3'd1;
        end else if (down_q) pos_q <= pos_q - 1'b1;
        else                 pos_q <= pos_q + 1'b1;
      end
    end
  end

  // error blinker, AAAA on the first phase
  assign led_err = blink_q ? 16'h5555 : 16'hAAAA;

  // logic view
  assign led_logic = {blink_q, &link_i, flash_i.gbt_req, flash_i.l1a, flash_i.resync,
                      flash_i.bc0, flash_i.vfat_reset, cluster_seen_i, bar_i};

  // scanner under the logic high byte
  assign led_cylon = {led_logic[15:8], 8'(8'd1 << pos_q)};

  always_comb begin
    case (mode_i)
      led_types_pkg::MODE_CYLON: led_sel = led_cylon;
      led_types_pkg::MODE_LOGIC: led_sel = led_logic;
      led_types_pkg::MODE_SYNC:  led_sel = ctrl_i.sync.pattern;
      default:                   led_sel = led_err;
    endcase
  end

  // output register
  always_ff @(posedge clock) begin
    if (rst_i) led_q <= '0;
    else       led_q <= led_sel;
  end

  assign led_o = led_q;

endmodule

// File: design/led_rate_bar.sv
`include "led_settings.svh"

module led_rate_bar (
  input  logic                   clock,
  input  logic                   rst_i,
  input  logic                   window_i,
  input  logic [7:0]             cluster_count_i,
  output logic                   cluster_any_o,
  output logic [`LED_RATE_W-1:0] rate_o,
  output logic [7:0]             bar_o
);

  logic [7:0]             count_q;
  logic [`LED_RATE_W-1:0] acc_q;
  logic [`LED_RATE_W-1:0] rate_q;
  logic [7:0]             bar_q;
  logic [7:0]             bar_next;

  // ---------------------------------------------------------------------
  // input register
  // ---------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (rst_i) count_q <= '0;
    else       count_q <= cluster_count_i;
  end

  assign cluster_any_o = (count_q != '0);

  // ---------------------------------------------------------------------
  // log bar, led k at base << k
  // ---------------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < 8; k++) begin
      bar_next[k] = (acc_q >= (`LED_RATE_W'(`LED_BAR_BASE) << k));
    end
  end

  // ---------------------------------------------------------------------
  // window accumulator
  // ---------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (rst_i) begin
      acc_q  <= '0;
      rate_q <= '0;
      bar_q  <= '0;
    end else if (window_i) begin
      // latch the finished sum
      rate_q <= acc_q;
      bar_q  <= bar_next;
      // new window starts with this cycle's count
      acc_q  <= `LED_RATE_W'(count_q);
    end else begin
      acc_q  <= acc_q + `LED_RATE_W'(count_q);
    end
  end

  assign rate_o = rate_q;
  assign bar_o  = bar_q;

endmodule

// File: design/led_settings.svh
`ifndef LED_SETTINGS_SVH
`define LED_SETTINGS_SVH

// ---------------------------------------------------------------------
// divider periods, in clock cycles
// ---------------------------------------------------------------------
`define LED_BLINK_DIV 8
`define LED_SCAN_DIV 4
`define LED_WINDOW_DIV 64

// ---------------------------------------------------------------------
// event flash and rate display
// ---------------------------------------------------------------------
// flash length after the last pulse
`define LED_FLASH_LEN 6

// threshold of bar led 0, doubles per led
`define LED_BAR_BASE 16

// width of the accumulated rate
`define LED_RATE_W 32

`endif

// File: design/led_tick_timer.sv
`include "led_settings.svh"

module led_tick_timer (
  input  logic                      clock,
  input  logic                      rst_i,
  output led_types_pkg::led_ticks_t ticks_o
);

  // one counter per tick: blink, scan, window
  localparam int unsigned NDIV = 3;
  localparam int unsigned DIV[NDIV] = '{`LED_BLINK_DIV, `LED_SCAN_DIV, `LED_WINDOW_DIV};

  // counter width from the longest period
  function automatic int unsigned max_div();
    int unsigned m;
    m = 1;
    for (int i = 0; i < NDIV; i++) begin
      if (DIV[i] > m) m = DIV[i];
    end
    return m;
  endfunction

  localparam int unsigned CW = $clog2(max_div());

  logic [CW-1:0]   cnt_q[NDIV];
  logic [NDIV-1:0] wrap;

  // last count of each period
  always_comb begin
    for (int i = 0; i < NDIV; i++) begin
      wrap[i] = (cnt_q[i] == CW'(DIV[i] - 1));
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NDIV; i++) begin
      if (rst_i || wrap[i]) cnt_q[i] <= '0;
      else                  cnt_q[i] <= cnt_q[i] + 1'b1;
    end
  end

  assign ticks_o.blink  = wrap[0];
  assign ticks_o.scan   = wrap[1];
  assign ticks_o.window = wrap[2];

endmodule

// File: design/led_types_pkg.sv
package led_types_pkg;

  // display modes, listed lowest to highest code
  typedef enum logic [1:0] {
    MODE_ERROR = 2'd0,
    MODE_CYLON = 2'd1,
    MODE_LOGIC = 2'd2,
    MODE_SYNC  = 2'd3
  } led_mode_e;

  // single-cycle strobes from the dividers
  typedef struct packed {
    logic blink;
    logic scan;
    logic window;
  } led_ticks_t;

  // raw trigger and link events, also used for the stretched flashes
  typedef struct packed {
    logic l1a;
    logic bc0;
    logic resync;
    logic vfat_reset;
    logic gbt_req;
  } led_events_t;

  // link status bits
  typedef struct packed {
    logic rx_ready;
    logic rx_valid;
    logic link_ready;
  } led_link_t;

  // ---------------------------------------------------------------------
  // control word, bit 31 picks which of the two readings applies
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic        sync_en;
    logic [14:0] rsvd;
    logic [15:0] pattern;
  } led_ctrl_sync_t;

  typedef struct packed {
    logic        sync_en;
    logic [29:0] rsvd;
    logic        cylon_skip;
  } led_ctrl_cfg_t;

  typedef union packed {
    led_ctrl_sync_t sync;
    led_ctrl_cfg_t  cfg;
  } led_ctrl_u;

endpackage

// File: tb.f
+incdir+design
design/led_types_pkg.sv
design/led_bus_pkg.sv
design/led_tick_timer.sv
design/led_mode_fsm.sv
design/led_event_flash.sv
design/led_rate_bar.sv
design/led_pattern_mux.sv
design/led_panel_top.sv
tb/tb_led_panel_assert.sv
tb/tb_led_panel.sv

// File: tb/led_panel_cases.txt
# name op a b expect, all numbers hex; status reads {seen, mode}
# ops 1 lock=a, 2 error pattern a cycles, 3 read adr a, 4 write adr a data b, 5 led&a
# ops 6 cylon a cycles with high byte, 7 clusters a for b cycles, 8 event a on led b, 9 link a
err_pattern     2 20 0 0
err_status      3 2 0 0
lock_up         1 1 0 0
link_up         9 7 0 0
cylon_scan      6 28 0 4000
cylon_status    3 2 0 1
skip_cylon      4 0 1 0
skip_status     3 2 0 2
skip_clear      4 0 0 0
sync_on         4 0 8000a5c3 0
sync_led        5 ffff 0 a5c3
sync_readback   3 0 0 8000a5c3
sync_off        4 0 0 0
sync_restore    3 2 0 1
l1a_flash       8 10 c 6
rate_low        7 3 c8 0
rate_low_rd     3 1 0 c0
bar_low         5 ff 0 f
seen_status     3 2 0 6
rate_high       7 20 c8 0
rate_high_rd    3 1 0 800
bar_high        5 ff 0 ff
rate_ro_wr      4 1 1234 0
rate_ro_rd      3 1 0 800
unmapped_rd     3 3 0 0
clusters_off    7 0 4 0
resync_flash    8 4 b 6
resync_status   3 2 0 1
lock_lost       1 0 0 0
err_again       2 20 0 0

// File: tb/tb_led_panel.sv
module tb_led_panel;
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [8*24-1:0] name_t;

  // operation codes of the case file
  localparam logic [7:0] OP_LOCK  = 8'h1;
  localparam logic [7:0] OP_ERR   = 8'h2;
  localparam logic [7:0] OP_READ  = 8'h3;
  localparam logic [7:0] OP_WRITE = 8'h4;
  localparam logic [7:0] OP_LED   = 8'h5;
  localparam logic [7:0] OP_CYLON = 8'h6;
  localparam logic [7:0] OP_COUNT = 8'h7;
  localparam logic [7:0] OP_FLASH = 8'h8;
  localparam logic [7:0] OP_LINK  = 8'h9;

  // cycles to wait for an ack
  localparam int unsigned ACK_LIMIT = 20;

  logic                       clock;
  logic                       rst_i;
  logic                       mmcm_locked_i;
  led_types_pkg::led_link_t   link_i;
  led_types_pkg::led_events_t events_i;
  logic [7:0]                 cluster_count_i;
  led_bus_pkg::wb_req_t       wb_req_i;
  led_bus_pkg::wb_rsp_t       wb_rsp_o;
  logic [15:0]                led_o;

  led_panel_top dut0 (
    .clock           (clock),
    .rst_i           (rst_i),
    .mmcm_locked_i   (mmcm_locked_i),
    .link_i          (link_i),
    .events_i        (events_i),
    .cluster_count_i (cluster_count_i),
    .wb_req_i        (wb_req_i),
    .wb_rsp_o        (wb_rsp_o),
    .led_o           (led_o)
  );

  // 100 ns period
  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input name_t name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail %0s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // wishbone classic master
  // ----------------------------------------------------------------------
  task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int unsigned gap;
    int unsigned waited;
    // random idle gap before the cycle
    gap = $urandom % 4;
    repeat (gap + 1) @(negedge clock);
    wb_req_i.cyc = 1'b1;
    wb_req_i.stb = 1'b1;
    wb_req_i.we  = we;
    wb_req_i.adr = adr;
    wb_req_i.dat = wdat;
    waited = 0;
    @(negedge clock);
    while (!wb_rsp_o.ack && waited < ACK_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (!wb_rsp_o.ack) begin
      $display("No Wishbone ack came back for address %0d", adr);
      abort_run();
    end
    // read data valid with ack, then release the bus
    rdat = wb_rsp_o.dat;
    wb_req_i = '0;
  endtask

  // ----------------------------------------------------------------------
  // display checks
  // ----------------------------------------------------------------------
  task automatic scan_error(input name_t name, input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clock);
      assert (led_o === 16'hAAAA || led_o === 16'h5555) else begin
        $display("Fail %0s expected AAAA or 5555 actual %h", name, led_o);
        abort_run();
      end
    end
  endtask

  task automatic scan_cylon(input name_t name, input int unsigned cycles, input logic [15:0] high);
    repeat (cycles) begin
      @(negedge clock);
      // one lit led in the low byte
      assert ($onehot(led_o[7:0])) else begin
        $display("Fail %0s expected one-hot low byte actual %h", name, led_o);
        abort_run();
      end
      // blink bit left out
      check_value(name, 32'(high), 32'(led_o & 16'h7f00));
    end
  endtask

  task automatic check_flash(input name_t name, input logic [4:0] ev, input int unsigned bit_idx,
                             input int unsigned len);
    @(negedge clock);
    events_i = led_types_pkg::led_events_t'(ev);
    @(negedge clock);
    events_i = '0;
    // sampling edge plus one, still dark
    @(negedge clock);
    check_value(name, 32'd0, 32'(led_o[bit_idx]));
    repeat (len) begin
      @(negedge clock);
      check_value(name, 32'd1, 32'(led_o[bit_idx]));
    end
    @(negedge clock);
    check_value(name, 32'd0, 32'(led_o[bit_idx]));
  endtask

  task automatic run_case(input name_t name, input logic [7:0] op, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] exp);
    logic [31:0] rdat;
    case (op)
      OP_LOCK: begin
        @(negedge clock);
        mmcm_locked_i = a[0];
        // input reg, fsm, output reg, margin
        repeat (4) @(negedge clock);
      end
      OP_ERR:   scan_error(name, a);
      OP_READ: begin
        bus_access(1'b0, a[1:0], 32'd0, rdat);
        check_value(name, exp, rdat);
      end
      OP_WRITE: begin
        bus_access(1'b1, a[1:0], b, rdat);
        // fsm, output register, margin
        repeat (3) @(negedge clock);
      end
      OP_LED: begin
        @(negedge clock);
        check_value(name, exp, 32'(led_o & a[15:0]));
      end
      OP_CYLON: scan_cylon(name, a, exp[15:0]);
      OP_COUNT: begin
        @(negedge clock);
        cluster_count_i = a[7:0];
        repeat (b) @(negedge clock);
      end
      OP_FLASH: check_flash(name, a[4:0], b, exp);
      OP_LINK: begin
        @(negedge clock);
        link_i = led_types_pkg::led_link_t'(a[2:0]);
        repeat (2) @(negedge clock);
      end
      default: begin
        $display("Unknown operation code %h in case %0s", op, name);
        abort_run();
      end
    endcase
  endtask

  // errors flagged by the bound checker
  always @(negedge clock) begin
    if (dut0.u_chk.err_seen === 1'b1) begin
      $display("A bound concurrent assertion failed");
      abort_run();
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int               fd;
    int               nread;
    int               nfield;
    int unsigned      ncases;
    logic [8*128-1:0] line;
    name_t            name;
    logic [31:0]      op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      exp;
    void'($urandom(32'h08dd_474e));
    rst_i           = 1'b1;
    mmcm_locked_i   = 1'b0;
    link_i          = '0;
    events_i        = '0;
    cluster_count_i = '0;
    wb_req_i        = '0;
    ncases          = 0;
    repeat (2) @(negedge clock);
    rst_i = 1'b0;
    repeat (2) @(negedge clock);
    fd = $fopen("tb/led_panel_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file tb/led_panel_cases.txt");
      abort_run();
    end else begin
      // comment lines give fewer than five fields
      while (!$feof(fd)) begin
        nread = $fgets(line, fd);
        if (nread != 0) begin
          nfield = $sscanf(line, "%s %h %h %h %h", name, op, a, b, exp);
          if (nfield == 5) begin
            run_case(name, op[7:0], a, b, exp);
            ncases++;
          end
        end
      end
      $fclose(fd);
    end
    if (ncases == 0) begin
      $display("The case file held no test lines");
      abort_run();
    end else if (dut0.u_chk.err_seen === 1'b1) begin
      $display("A bound concurrent assertion failed");
      abort_run();
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: tb/tb_led_panel_assert.sv
module tb_led_panel_assert (
  input logic                     clock,
  input logic                     rst_i,
  input logic                     mmcm_locked_i,
  input led_bus_pkg::wb_req_t     req_i,
  input led_bus_pkg::wb_rsp_t     rsp_i,
  input logic [15:0]              led_i,
  input led_types_pkg::led_mode_e mode_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic err_seen;
  logic req;

  initial err_seen = 1'b0;

  assign req = req_i.cyc && req_i.stb;

  // ---------------------------------------------------------------------
  // bus handshake
  // ---------------------------------------------------------------------
  ack_single: assert property (@(posedge clock) disable iff (rst_i) rsp_i.ack |=> !rsp_i.ack)
    else begin
      $error("ack stayed high for more than one cycle");
      err_seen = 1'b1;
    end

  ack_after_req: assert property (@(posedge clock) disable iff (rst_i) rsp_i.ack |-> $past(req))
    else begin
      $error("ack without a request in the cycle before");
      err_seen = 1'b1;
    end

  // ---------------------------------------------------------------------
  // display outputs
  // ---------------------------------------------------------------------
  led_dark_after_rst: assert property (@(posedge clock) rst_i |=> led_i == 16'd0)
    else begin
      $error("leds not dark in the cycle after reset");
      err_seen = 1'b1;
    end

  // mode trails the lock input by the input register and the fsm register
  // unlocked means error display, so never the host pattern
  error_while_unlocked: assert property (@(posedge clock) disable iff (rst_i)
    $past(!mmcm_locked_i, 2) |-> mode_i == led_types_pkg::MODE_ERROR)
    else begin
      $error("display left error mode while the clock manager is unlocked");
      err_seen = 1'b1;
    end

endmodule

bind led_panel_top tb_led_panel_assert u_chk (
  .clock         (clock),
  .rst_i         (rst_i),
  .mmcm_locked_i (mmcm_locked_i),
  .req_i         (wb_req_i),
  .rsp_i         (wb_rsp_o),
  .led_i         (led_o),
  .mode_i        (mode)
);
